/* src/cpu_boot_config.svh */
`ifndef CPU_BOOT_CONFIG_SVH
`define CPU_BOOT_CONFIG_SVH

////////////////////////////////////////
// memory geometry
////////////////////////////////////////

`define WORD_BYTES      4           // bytes per word
`define BLOCK_WORDS     16          // words moved per host transfer
`define BLOCK_BYTES     16'h0040    // block stride in byte space

`define DM_BLOCKS       17          // data blocks, one per table entry
`define IM_BLOCKS       48          // instruction blocks, contiguous from 0

////////////////////////////////////////
// host addressing
////////////////////////////////////////

// ex_addr bit that tags an instruction block request
`define IM_HOST_SELECT  16

`endif

/* src/host_pkg.sv */
// host side of the boot link
package host_pkg;

    ////////////////////////////////////////
    // host opcode
    ////////////////////////////////////////

    // 2'b11 reserved
    typedef enum logic [1:0] {
        IDLE = 2'b00,   // no request
        READ = 2'b01    // block read from host
    } host_op_t;

    ////////////////////////////////////////
    // loader FSM
    ////////////////////////////////////////

    // data blocks go first, then instruction blocks
    typedef enum logic [2:0] {
        BOOT_IDLE,      // waiting on host ready
        WAIT_DM,        // data block requested
        LOAD_DM,        // data words streaming in
        WAIT_IM,        // instruction block requested
        LOAD_IM,        // instruction words streaming in
        RUN             // boot finished
    } loader_state_t;

    ////////////////////////////////////////
    // host address
    ////////////////////////////////////////

    // only the low half and the select bit carry meaning
    typedef logic [63:0] host_addr_t;

endpackage

/* src/mem_pkg.sv */
`include "cpu_boot_config.svh"

// memory side types and the data block map
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`BLOCK_WORDS*32-1:0] line_t;     // word 0 in the low bits
    typedef logic [15:0] mem_addr_t;                // byte address

    typedef logic [$clog2(`DM_BLOCKS)-1:0] dm_slot_t;
    typedef logic [$clog2(`BLOCK_WORDS)-1:0] word_sel_t;
    typedef logic [$clog2(`IM_BLOCKS*`BLOCK_WORDS)-1:0] im_idx_t;

    typedef struct packed {
        logic hit;
        dm_slot_t slot;
    } dm_lookup_t;

    ////////////////////////////////////////
    // data block base addresses
    ////////////////////////////////////////

    // slot n of data memory backs entry n
    parameter mem_addr_t DM_BLOCK_TABLE [0:`DM_BLOCKS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

    // block base of addr against the table, miss gives hit low
    function automatic dm_lookup_t dm_slot_lookup(input mem_addr_t addr);
        dm_lookup_t res;
        mem_addr_t base;
        res = '0;
        base = addr & ~mem_addr_t'(`BLOCK_BYTES - 1);   // drop offset in block
        for (int i = 0; i < `DM_BLOCKS; i++) begin
            if (DM_BLOCK_TABLE[i] == base) begin
                res.hit = 1'b1;
                res.slot = dm_slot_t'(i);
            end
        end
        return res;
    endfunction

endpackage

/* src/boot_wr_if.sv */
// loader write path into both memories
interface boot_wr_if import mem_pkg::*; ();

    logic im_en;        // instruction memory write strobe
    logic dm_en;        // data memory write strobe
    mem_addr_t addr;    // byte address, shared
    word_t data;

    modport loader (
        output im_en, dm_en, addr, data
    );

    modport im_side (
        input im_en, addr, data
    );

    modport dm_side (
        input dm_en, addr, data
    );

endinterface

/* src/host_loader.sv */
`include "cpu_boot_config.svh"

module host_loader import host_pkg::*, mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ready,
    input  logic        rd_valid,
    input  logic        tx_done,
    input  word_t       ex_wrt_data,
    output host_addr_t  ex_addr,
    output host_op_t    op,
    output logic        running,
    boot_wr_if.loader   wr
);

    typedef logic [$clog2(`IM_BLOCKS)-1:0] im_blk_t;

    localparam host_addr_t IM_SELECT_BIT = host_addr_t'(1) << `IM_HOST_SELECT;

    loader_state_t state, next_state;

    dm_slot_t  dm_count;    // current data block
    im_blk_t   im_count;    // current instruction block
    mem_addr_t word_addr;   // address of the next streamed word

    mem_addr_t dm_base, im_base, blk_base;
    logic      blk_start;   // word 0 present
    logic      loading;
    logic      last_dm, last_im;

    ////////////////////////////////////////
    // block addressing
    ////////////////////////////////////////

    assign dm_base  = DM_BLOCK_TABLE[dm_count];
    assign im_base  = mem_addr_t'(im_count) * `BLOCK_BYTES;  // contiguous space
    assign blk_base = (state == WAIT_DM) ? dm_base : im_base;

    assign blk_start = ((state == WAIT_DM) || (state == WAIT_IM)) && rd_valid;
    assign loading   = (state == LOAD_DM) || (state == LOAD_IM);

    assign last_dm = (dm_count == dm_slot_t'(`DM_BLOCKS - 1));
    assign last_im = (im_count == im_blk_t'(`IM_BLOCKS - 1));

    ////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= BOOT_IDLE;
            dm_count  <= '0;
            im_count  <= '0;
            word_addr <= '0;
        end else begin
            state <= next_state;
            if (blk_start)
                word_addr <= blk_base + mem_addr_t'(`WORD_BYTES);  // word 1 next
            else if (loading)
                word_addr <= word_addr + mem_addr_t'(`WORD_BYTES);
            if ((state == LOAD_DM) && tx_done && !last_dm)
                dm_count <= dm_count + 1'b1;
            if ((state == LOAD_IM) && tx_done && !last_im)
                im_count <= im_count + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            BOOT_IDLE: begin
                if (ready)
                    next_state = WAIT_DM;
            end
            WAIT_DM: begin
                if (rd_valid)
                    next_state = LOAD_DM;
            end
            LOAD_DM: begin
                if (tx_done)
                    next_state = last_dm ? WAIT_IM : WAIT_DM;
            end
            WAIT_IM: begin
                if (rd_valid)
                    next_state = LOAD_IM;
            end
            LOAD_IM: begin
                if (tx_done)
                    next_state = last_im ? RUN : WAIT_IM;
            end
            RUN: next_state = RUN;      // left only through reset
            default: next_state = BOOT_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // host request
    ////////////////////////////////////////

    // request held only while waiting on the host
    always_comb begin
        op = IDLE;
        ex_addr = '0;
        case (state)
            WAIT_DM: begin
                op = READ;
                ex_addr = host_addr_t'(dm_base);
            end
            WAIT_IM: begin
                op = READ;
                ex_addr = host_addr_t'(im_base) | IM_SELECT_BIT;
            end
            default: begin
                op = IDLE;
                ex_addr = '0;
            end
        endcase
    end

    assign running = (state == RUN);

    // one write per word, in the cycle the host shows it
    assign wr.dm_en = ((state == WAIT_DM) && rd_valid) || (state == LOAD_DM);
    assign wr.im_en = ((state == WAIT_IM) && rd_valid) || (state == LOAD_IM);
    assign wr.addr  = loading ? word_addr : blk_base;
    assign wr.data  = ex_wrt_data;

endmodule

/* src/instr_mem.sv */
`include "cpu_boot_config.svh"

module instr_mem import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_addr_t   fetch_addr,
    output word_t       fetch_instr,
    boot_wr_if.im_side  wr
);

    localparam int IM_WORDS = `IM_BLOCKS * `BLOCK_WORDS;

    word_t mem [0:IM_WORDS-1];

    im_idx_t wr_idx, rd_idx;

    // byte address to word index
    assign wr_idx = im_idx_t'(wr.addr / `WORD_BYTES);
    assign rd_idx = im_idx_t'(fetch_addr / `WORD_BYTES);

    ////////////////////////////////////////
    // loader write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.im_en)
            mem[wr_idx] <= wr.data;
    end

    ////////////////////////////////////////
    // fetch read, one cycle
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            fetch_instr <= '0;      // nop until first fetch
        else
            fetch_instr <= mem[rd_idx];
    end

endmodule

/* src/data_mem.sv */
`include "cpu_boot_config.svh"

module data_mem import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_addr_t   accel_addr,
    input  word_t       accel_wrt_data,
    input  logic        accel_wrt_en,
    input  logic        accel_rd_en,
    output logic        accel_wrt_done,
    output logic        accel_rd_valid,
    output line_t       accel_rd_data,
    boot_wr_if.dm_side  wr
);

    localparam int WORD_W = $bits(word_t);

    // one slot per table entry
    word_t mem [0:`DM_BLOCKS-1][0:`BLOCK_WORDS-1];

    mem_addr_t  wr_addr;
    word_t      wr_data;
    logic       wr_en;
    word_sel_t  wr_sel;
    dm_lookup_t wr_lk, rd_lk;

    ////////////////////////////////////////
    // write port select
    ////////////////////////////////////////

    // loader wins over the accelerator
    always_comb begin
        if (wr.dm_en) begin
            wr_addr = wr.addr;
            wr_data = wr.data;
        end else begin
            wr_addr = accel_addr;
            wr_data = accel_wrt_data;
        end
    end

    assign wr_en  = wr.dm_en | accel_wrt_en;
    assign wr_lk  = dm_slot_lookup(wr_addr);
    assign rd_lk  = dm_slot_lookup(accel_addr);
    assign wr_sel = word_sel_t'(wr_addr / `WORD_BYTES);     // word within block

    always_ff @(posedge clk) begin
        if (wr_en && wr_lk.hit)     // unmapped writes fall away
            mem[wr_lk.slot][wr_sel] <= wr_data;
    end

    ////////////////////////////////////////
    // line read
    ////////////////////////////////////////

    // whole block gathered, held until the next read
    always_ff @(posedge clk) begin
        if (accel_rd_en) begin
            for (int w = 0; w < `BLOCK_WORDS; w++) begin
                accel_rd_data[w*WORD_W +: WORD_W] <= rd_lk.hit ? mem[rd_lk.slot][w] : '0;
            end
        end
    end

    ////////////////////////////////////////
    // completion strobes
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wrt_done <= accel_wrt_en;     // done even on a miss
            accel_rd_valid <= accel_rd_en;
        end
    end

endmodule

/* src/cpu_boot_top.sv */
module cpu_boot_top import host_pkg::*, mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // host link
    input  logic        ready,
    input  logic        rd_valid,
    input  logic        tx_done,
    input  word_t       ex_wrt_data,
    output host_addr_t  ex_addr,
    output host_op_t    op,
    output logic        running,

    // fetch port
    input  mem_addr_t   fetch_addr,
    output word_t       fetch_instr,

    // accelerator port
    input  mem_addr_t   accel_addr,
    input  word_t       accel_wrt_data,
    input  logic        accel_wrt_en,
    input  logic        accel_rd_en,
    output logic        accel_wrt_done,
    output logic        accel_rd_valid,
    output line_t       accel_rd_data
);

    boot_wr_if boot_wr ();      // loader to both memories

    host_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .rd_valid    (rd_valid),
        .tx_done     (tx_done),
        .ex_wrt_data (ex_wrt_data),
        .ex_addr     (ex_addr),
        .op          (op),
        .running     (running),
        .wr          (boot_wr.loader)
    );

    instr_mem u_imem (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .wr          (boot_wr.im_side)
    );

    data_mem u_dmem (
        .clk            (clk),
        .rst_n          (rst_n),
        .accel_addr     (accel_addr),
        .accel_wrt_data (accel_wrt_data),
        .accel_wrt_en   (accel_wrt_en),
        .accel_rd_en    (accel_rd_en),
        .accel_wrt_done (accel_wrt_done),
        .accel_rd_valid (accel_rd_valid),
        .accel_rd_data  (accel_rd_data),
        .wr             (boot_wr.dm_side)
    );

endmodule

/* tests/cpu_boot_properties.sv */
// handshake rules on the top level, bound into cpu_boot_top
module cpu_boot_properties import host_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     accel_rd_en,
    input logic     accel_rd_valid,
    input logic     accel_wrt_en,
    input logic     accel_wrt_done,
    input logic     running,
    input host_op_t op
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // read by the testbench at the end

    a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accel_rd_en |=> accel_rd_valid)
        else begin
            fail_count++;
            $error("line read gave no valid one cycle later");
        end

    a_wrt_done: assert property (@(posedge clk) disable iff (!rst_n)
        accel_wrt_en |=> accel_wrt_done)
        else begin
            fail_count++;
            $error("word write gave no done one cycle later");
        end

    a_run_hold: assert property (@(posedge clk) disable iff (!rst_n)
        running |=> running)
        else begin
            fail_count++;
            $error("running fell before reset");
        end

    a_run_idle: assert property (@(posedge clk) disable iff (!rst_n)
        running |-> (op == IDLE))
        else begin
            fail_count++;
            $error("host request seen after boot");
        end

endmodule

bind cpu_boot_top cpu_boot_properties u_props (.*);

/* tests/cpu_boot_tb.sv */
`include "cpu_boot_config.svh"

module cpu_boot_tb import host_pkg::*, mem_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IM_WORDS = `IM_BLOCKS * `BLOCK_WORDS;
    localparam int TIMEOUT_CYCLES = (`DM_BLOCKS + `IM_BLOCKS) * 24 + 768 + 400 + 500;

    logic clk, rst_n, ready, rd_valid, tx_done;
    word_t ex_wrt_data, fetch_instr, accel_wrt_data;
    host_addr_t ex_addr;
    host_op_t op;
    logic running, accel_wrt_en, accel_rd_en, accel_wrt_done, accel_rd_valid;
    mem_addr_t fetch_addr, accel_addr;
    line_t accel_rd_data;

    word_t im_model [0:IM_WORDS-1];                         // what the host sent
    word_t dm_model [0:`DM_BLOCKS-1][0:`BLOCK_WORDS-1];
    mem_addr_t dm_base [0:`DM_BLOCKS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140, 16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140, 16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

    logic [16:0] lfsr;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    cpu_boot_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ready          (ready),
        .rd_valid       (rd_valid),
        .tx_done        (tx_done),
        .ex_wrt_data    (ex_wrt_data),
        .ex_addr        (ex_addr),
        .op             (op),
        .running        (running),
        .fetch_addr     (fetch_addr),
        .fetch_instr    (fetch_instr),
        .accel_addr     (accel_addr),
        .accel_wrt_data (accel_wrt_data),
        .accel_wrt_en   (accel_wrt_en),
        .accel_rd_en    (accel_rd_en),
        .accel_wrt_done (accel_wrt_done),
        .accel_rd_valid (accel_rd_valid),
        .accel_rd_data  (accel_rd_data)
    );

    ////////////////////////////////////////
    // clock and timeout
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // fibonacci lfsr, taps 17 and 14, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // host side of one block transfer
    task automatic serve_block(input host_addr_t exp_addr, input bit to_im, input int blk);
        int gap;
        word_t w;
        while (op != READ)
            @(negedge clk);
        compare("running", running, 1'b0);
        compare("ex_addr", ex_addr, exp_addr);
        gap = rand_bits(3);                 // 0 to 7 idle cycles
        repeat (gap) begin
            @(negedge clk);
            compare("op", op, READ);        // request held while host is silent
            compare("ex_addr", ex_addr, exp_addr);
        end
        for (int k = 0; k < `BLOCK_WORDS; k++) begin
            w = rand_bits(32);
            rd_valid = (k == 0);
            tx_done = (k == `BLOCK_WORDS - 1);
            ex_wrt_data = w;
            if (to_im)
                im_model[blk * `BLOCK_WORDS + k] = w;
            else
                dm_model[blk][k] = w;
            if (k == `BLOCK_WORDS - 1)
                compare("running", running, 1'b0);  // still booting on tx_done
            @(negedge clk);
        end
        rd_valid = 1'b0;
        tx_done = 1'b0;
    endtask

    task automatic read_line(input mem_addr_t addr);
        accel_addr = addr;
        accel_rd_en = 1'b1;
        @(negedge clk);
        accel_rd_en = 1'b0;
        compare("accel_rd_valid", accel_rd_valid, 1'b1);
        compare("accel_wrt_done", accel_wrt_done, 1'b0);
    endtask

    task automatic accel_write(input mem_addr_t addr, input word_t data);
        accel_addr = addr;
        accel_wrt_data = data;
        accel_wrt_en = 1'b1;
        @(negedge clk);
        accel_wrt_en = 1'b0;
        compare("accel_wrt_done", accel_wrt_done, 1'b1);
        compare("accel_rd_valid", accel_rd_valid, 1'b0);
    endtask

    task automatic check_block(input int slot);
        mem_addr_t off;
        off = mem_addr_t'(rand_bits(6));    // any byte in the block
        read_line(dm_base[slot] | off);
        for (int w = 0; w < `BLOCK_WORDS; w++)
            compare($sformatf("accel_rd_data slot %0d word %0d", slot, w),
                    accel_rd_data[w*32 +: 32], dm_model[slot][w]);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int slot;
        int wsel;
        word_t wdata;
        lfsr = 17'd78181;
        rst_n = 1'b0;
        ready = 1'b0;
        rd_valid = 1'b0;
        tx_done = 1'b0;
        ex_wrt_data = '0;
        fetch_addr = '0;
        accel_addr = '0;
        accel_wrt_data = '0;
        accel_wrt_en = 1'b0;
        accel_rd_en = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        compare("op", op, IDLE);
        compare("ex_addr", ex_addr, '0);
        compare("running", running, 1'b0);
        compare("accel_wrt_done", accel_wrt_done, 1'b0);
        compare("accel_rd_valid", accel_rd_valid, 1'b0);
        ready = 1'b1;

        // boot, data blocks first
        for (int i = 0; i < `DM_BLOCKS; i++)
            serve_block(host_addr_t'(dm_base[i]), 1'b0, i);
        for (int n = 0; n < `IM_BLOCKS; n++)
            serve_block((host_addr_t'(1) << `IM_HOST_SELECT) | host_addr_t'(n * 64), 1'b1, n);
        compare("running", running, 1'b1);
        compare("op", op, IDLE);

        for (int i = 0; i < IM_WORDS; i++) begin
            fetch_addr = mem_addr_t'(i * `WORD_BYTES);
            @(negedge clk);
            compare($sformatf("fetch_instr %0d", i), fetch_instr, im_model[i]);
        end

        for (int i = 0; i < `DM_BLOCKS; i++)
            check_block(i);

        // random accelerator writes, each block read back
        for (int n = 0; n < 40; n++) begin
            slot = rand_bits(5) % `DM_BLOCKS;
            wsel = rand_bits(4);
            wdata = rand_bits(32);
            accel_write(dm_base[slot] + mem_addr_t'(wsel * `WORD_BYTES), wdata);
            dm_model[slot][wsel] = wdata;
            check_block(slot);
        end

        accel_write(16'h5008, rand_bits(32));   // unmapped, dropped
        read_line(16'h5000);
        compare("accel_rd_data unmapped", accel_rd_data[63:0], '0);
        for (int w = 2; w < `BLOCK_WORDS; w += 2)
            compare("accel_rd_data unmapped", accel_rd_data[w*32 +: 64], '0);
        for (int i = 0; i < `DM_BLOCKS; i++)
            check_block(i);                     // no slot took the dropped word

        errors += u_dut.u_props.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_props.fail_count);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* cpu_boot.f */
+incdir+src
src/host_pkg.sv
src/mem_pkg.sv
src/boot_wr_if.sv
src/host_loader.sv
src/instr_mem.sv
src/data_mem.sv
src/cpu_boot_top.sv
tests/cpu_boot_properties.sv
tests/cpu_boot_tb.sv

/* Bender.yml */
package:
  name: cpu_boot

sources:
  - include_dirs:
      - src
    files:
      - src/host_pkg.sv
      - src/mem_pkg.sv
      - src/boot_wr_if.sv
      - src/host_loader.sv
      - src/instr_mem.sv
      - src/data_mem.sv
      - src/cpu_boot_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/cpu_boot_properties.sv
      - tests/cpu_boot_tb.sv
